//--- hw/rv_core_config.svh
// core width, register count and tag width macros.
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// ============================================================================
// datapath.
// ============================================================================

// width of one data or pc word.
`define RV_XLEN 32

// architectural integer registers, x0 included.
`define RV_REG_COUNT 32

// ============================================================================
// bookkeeping.
// ============================================================================

// instruction tag carried from input to completion.
`define RV_TAG_WIDTH 16

`endif

//--- hw/rv_isa_pkg.sv
// instruction-set field widths, word types, opcode and funct encodings.
`include "rv_core_config.svh"

package rv_isa_pkg;

    // ========================================================================
    // field widths.
    // ========================================================================
    localparam int INST_W     = 32;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int REG_ADDR_W = $clog2(`RV_REG_COUNT);
    // shift amount, low bits of operand 2 or the shamt field.
    localparam int SHAMT_W    = $clog2(`RV_XLEN);

    // ========================================================================
    // basic types.
    // ========================================================================
    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ========================================================================
    // encodings.
    // ========================================================================

    // major opcodes kept by this slice.
    typedef enum logic [OPCODE_W-1:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // funct3 of the integer alu group.
    typedef enum logic [FUNCT3_W-1:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SR      = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    // funct7, alternate form selects sub and sra.
    localparam logic [FUNCT7_W-1:0] FUNCT7_NORMAL = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] FUNCT7_ALT    = 7'b0100000;

endpackage

//--- hw/rv_pipe_pkg.sv
// pipeline control enums and the packed structs passed between stages.
`include "rv_core_config.svh"

package rv_pipe_pkg;

    import rv_isa_pkg::*;

    typedef logic [`RV_TAG_WIDTH-1:0] tag_t;

    // ========================================================================
    // control encodings.
    // ========================================================================

    // alu function, copy2 passes operand 2 through.
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,
        ALU_SLTU  = 4'd9,
        ALU_COPY2 = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        OP1_RS1  = 2'd0,
        OP1_PC   = 2'd1,
        OP1_ZERO = 2'd2
    } op1_sel_e;

    typedef enum logic {
        OP2_RS2 = 1'b0,
        OP2_IMM = 1'b1
    } op2_sel_e;

    // ========================================================================
    // stage payloads.
    // ========================================================================
    typedef struct packed {
        inst_t inst;
        word_t pc;
        tag_t  tag;
    } core_in_t;

    typedef struct packed {
        alu_op_e   alu_op;
        op1_sel_e  op1_sel;
        op2_sel_e  op2_sel;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      rf_wen;
        word_t     imm;
        word_t     pc;
        tag_t      tag;
    } dec_ctrl_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      rf_wen;
        word_t     value;
        tag_t      tag;
    } exe_out_t;

    // completion record at the core boundary.
    typedef struct packed {
        reg_addr_t rd;
        logic      rf_wen;
        word_t     value;
        tag_t      tag;
    } core_out_t;

endpackage

//--- hw/rv_decode.sv
// decode stage: field extraction, decode table, immediates, decode register.
`timescale 1ns/1ns

module rv_decode
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  core_in_t  core_in,
    output logic      dec_valid,
    output dec_ctrl_t dec_ctrl
);

    // which immediate the instruction carries.
    typedef enum logic [1:0] {
        IMM_I     = 2'd0,
        IMM_SHAMT = 2'd1,
        IMM_U     = 2'd2
    } imm_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        op1_sel_e op1_sel;
        op2_sel_e op2_sel;
        imm_sel_e imm_sel;
        logic     rf_wen;
    } dec_fields_t;

    // ========================================================================
    // decode table.
    // ========================================================================
    function automatic dec_fields_t decode_inst(
        input logic [FUNCT7_W+FUNCT3_W+OPCODE_W-1:0] key
    );
        dec_fields_t d;
        casez (key)
            {FUNCT7_NORMAL, F3_ADD_SUB, OPC_OP}: d = '{ALU_ADD,  OP1_RS1, OP2_RS2, IMM_I, 1'b1};
            {FUNCT7_ALT,    F3_ADD_SUB, OPC_OP}: d = '{ALU_SUB,  OP1_RS1, OP2_RS2, IMM_I, 1'b1};
            {FUNCT7_NORMAL, F3_SLL,     OPC_OP}: d = '{ALU_SLL,  OP1_RS1, OP2_RS2, IMM_I, 1'b1};
            {FUNCT7_NORMAL, F3_SLT,     OPC_OP}: d = '{ALU_SLT,  OP1_RS1, OP2_RS2, IMM_I, 1'b1};
            {FUNCT7_NORMAL, F3_SLTU,    OPC_OP}: d = '{ALU_SLTU, OP1_RS1, OP2_RS2, IMM_I, 1'b1};
            {FUNCT7_NORMAL, F3_XOR,     OPC_OP}: d = '{ALU_XOR,  OP1_RS1, OP2_RS2, IMM_I, 1'b1};
            {FUNCT7_NORMAL, F3_SR,      OPC_OP}: d = '{ALU_SRL,  OP1_RS1, OP2_RS2, IMM_I, 1'b1};
            {FUNCT7_ALT,    F3_SR,      OPC_OP}: d = '{ALU_SRA,  OP1_RS1, OP2_RS2, IMM_I, 1'b1};
            {FUNCT7_NORMAL, F3_OR,      OPC_OP}: d = '{ALU_OR,   OP1_RS1, OP2_RS2, IMM_I, 1'b1};
            {FUNCT7_NORMAL, F3_AND,     OPC_OP}: d = '{ALU_AND,  OP1_RS1, OP2_RS2, IMM_I, 1'b1};
            // immediate forms, funct7 only matters for shifts.
            {7'b???????, F3_ADD_SUB, OPC_OP_IMM}: d = '{ALU_ADD, OP1_RS1, OP2_IMM, IMM_I, 1'b1};
            {7'b???????, F3_SLT,     OPC_OP_IMM}: d = '{ALU_SLT, OP1_RS1, OP2_IMM, IMM_I, 1'b1};
            {7'b???????, F3_SLTU,    OPC_OP_IMM}: d = '{ALU_SLTU, OP1_RS1, OP2_IMM, IMM_I, 1'b1};
            {7'b???????, F3_XOR,     OPC_OP_IMM}: d = '{ALU_XOR, OP1_RS1, OP2_IMM, IMM_I, 1'b1};
            {7'b???????, F3_OR,      OPC_OP_IMM}: d = '{ALU_OR,  OP1_RS1, OP2_IMM, IMM_I, 1'b1};
            {7'b???????, F3_AND,     OPC_OP_IMM}: d = '{ALU_AND, OP1_RS1, OP2_IMM, IMM_I, 1'b1};
            {FUNCT7_NORMAL, F3_SLL, OPC_OP_IMM}: d = '{ALU_SLL, OP1_RS1, OP2_IMM, IMM_SHAMT, 1'b1};
            {FUNCT7_NORMAL, F3_SR,  OPC_OP_IMM}: d = '{ALU_SRL, OP1_RS1, OP2_IMM, IMM_SHAMT, 1'b1};
            {FUNCT7_ALT,    F3_SR,  OPC_OP_IMM}: d = '{ALU_SRA, OP1_RS1, OP2_IMM, IMM_SHAMT, 1'b1};
            // upper immediates.
            {7'b???????, 3'b???, OPC_LUI}:   d = '{ALU_COPY2, OP1_ZERO, OP2_IMM, IMM_U, 1'b1};
            {7'b???????, 3'b???, OPC_AUIPC}: d = '{ALU_ADD,   OP1_PC,   OP2_IMM, IMM_U, 1'b1};
            // anything else completes as a nop.
            default: d = '{ALU_ADD, OP1_ZERO, OP2_IMM, IMM_I, 1'b0};
        endcase
        return d;
    endfunction

    // ========================================================================
    // field extraction and immediates.
    // ========================================================================
    inst_t                inst;
    logic [OPCODE_W-1:0]  opcode;
    logic [FUNCT3_W-1:0]  funct3;
    logic [FUNCT7_W-1:0]  funct7;
    reg_addr_t            rd;
    dec_fields_t          fields;
    word_t                imm;
    dec_ctrl_t            dec_next;

    assign inst   = core_in.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign fields = decode_inst({funct7, funct3, opcode});

    always_comb begin
        case (fields.imm_sel)
            IMM_SHAMT: imm = word_t'(inst[20 +: SHAMT_W]);
            IMM_U:     imm = {inst[31:12], 12'b0};
            default:   imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

    always_comb begin
        dec_next.alu_op  = fields.alu_op;
        dec_next.op1_sel = fields.op1_sel;
        dec_next.op2_sel = fields.op2_sel;
        dec_next.rs1     = inst[19:15];
        dec_next.rs2     = inst[24:20];
        dec_next.rd      = rd;
        // x0 is never written.
        dec_next.rf_wen  = fields.rf_wen && (rd != '0);
        dec_next.imm     = imm;
        dec_next.pc      = core_in.pc;
        dec_next.tag     = core_in.tag;
    end

    // ========================================================================
    // decode register.
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec_ctrl <= dec_next;
        end
    end

endmodule

//--- hw/rv_execute.sv
// execute stage: operand select with forwarding, alu, execute register.
`timescale 1ns/1ns

module rv_execute
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      dec_valid,
    input  dec_ctrl_t dec_ctrl,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output logic      exe_valid,
    output exe_out_t  exe_out
);

    logic               fwd_rs1;
    logic               fwd_rs2;
    word_t              rs1_val;
    word_t              rs2_val;
    word_t              op1;
    word_t              op2;
    logic [SHAMT_W-1:0] shamt;
    word_t              alu_result;

    assign rs1 = dec_ctrl.rs1;
    assign rs2 = dec_ctrl.rs2;

    // previous instruction still sits in our own register.
    assign fwd_rs1 = exe_valid && exe_out.rf_wen && (exe_out.rd != '0) && (exe_out.rd == rs1);
    assign fwd_rs2 = exe_valid && exe_out.rf_wen && (exe_out.rd != '0) && (exe_out.rd == rs2);

    assign rs1_val = fwd_rs1 ? exe_out.value : rs1_data;
    assign rs2_val = fwd_rs2 ? exe_out.value : rs2_data;

    always_comb begin
        case (dec_ctrl.op1_sel)
            OP1_RS1: op1 = rs1_val;
            OP1_PC:  op1 = dec_ctrl.pc;
            default: op1 = '0;
        endcase
    end

    assign op2   = (dec_ctrl.op2_sel == OP2_IMM) ? dec_ctrl.imm : rs2_val;
    assign shamt = op2[SHAMT_W-1:0];

    // ========================================================================
    // alu.
    // ========================================================================
    always_comb begin
        case (dec_ctrl.alu_op)
            ALU_SUB:   alu_result = op1 - op2;
            ALU_AND:   alu_result = op1 & op2;
            ALU_OR:    alu_result = op1 | op2;
            ALU_XOR:   alu_result = op1 ^ op2;
            ALU_SLL:   alu_result = op1 << shamt;
            ALU_SRL:   alu_result = op1 >> shamt;
            ALU_SRA:   alu_result = $signed(op1) >>> shamt;
            ALU_SLT:   alu_result = word_t'($signed(op1) < $signed(op2));
            ALU_SLTU:  alu_result = word_t'(op1 < op2);
            ALU_COPY2: alu_result = op2;
            default:   alu_result = op1 + op2;
        endcase
    end

    // ========================================================================
    // execute register.
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            exe_out.rd     <= dec_ctrl.rd;
            exe_out.rf_wen <= dec_ctrl.rf_wen;
            exe_out.value  <= alu_result;
            exe_out.tag    <= dec_ctrl.tag;
        end
    end

endmodule

//--- hw/rv_result.sv
// result stage: register file, two read ports, completion output register.
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_result
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      exe_valid,
    input  exe_out_t  exe_out,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    output logic      out_valid,
    output core_out_t core_out
);

    word_t regs [`RV_REG_COUNT];

    // register file, architectural state starts at zero.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (exe_valid && exe_out.rf_wen && (exe_out.rd != '0)) begin
            regs[exe_out.rd] <= exe_out.value;
        end
    end

    // x0 reads as zero.
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // ========================================================================
    // completion output.
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid) begin
            core_out.rd     <= exe_out.rd;
            core_out.rf_wen <= exe_out.rf_wen;
            core_out.value  <= exe_out.value;
            core_out.tag    <= exe_out.tag;
        end
    end

endmodule

//--- hw/rv_int_core.sv
// integer execution slice top: decode, execute and result stages.
`timescale 1ns/1ns

module rv_int_core
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  core_in_t  core_in,
    output logic      out_valid,
    output core_out_t core_out
);

    // decode to execute.
    logic      dec_valid;
    dec_ctrl_t dec_ctrl;

    // register read ports.
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;

    // execute to result.
    logic      exe_valid;
    exe_out_t  exe_out;

    rv_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .core_in   (core_in),
        .dec_valid (dec_valid),
        .dec_ctrl  (dec_ctrl)
    );

    rv_execute u_execute (
        .clk       (clk),
        .reset     (reset),
        .dec_valid (dec_valid),
        .dec_ctrl  (dec_ctrl),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .exe_valid (exe_valid),
        .exe_out   (exe_out)
    );

    rv_result u_result (
        .clk       (clk),
        .reset     (reset),
        .exe_valid (exe_valid),
        .exe_out   (exe_out),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .out_valid (out_valid),
        .core_out  (core_out)
    );

endmodule

//--- tb/tb_rv_int_core.sv
// stimulus, reference model, comparison and watchdog for the rv_int_core testbench.
`timescale 1ns/1ns
`include "rv_core_config.svh"

module tb_rv_int_core
    import rv_isa_pkg::*, rv_pipe_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int ALU_ROUNDS = 4;
    localparam int CHAIN_LEN  = 150;
    localparam int N_ODD      = 24;
    localparam int MAX_GAP    = 3;
    localparam int TOTAL_INSTS = 31 + ALU_ROUNDS * 21 * 5 + 2 * CHAIN_LEN + 2 * N_ODD + 31;
    // every instruction may be followed by the longest gap.
    localparam int WATCHDOG_CYCLES = TOTAL_INSTS * (MAX_GAP + 1) + 200;

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid;
    core_in_t    core_in;
    logic        out_valid;
    core_out_t   core_out;

    word_t       model_regs [`RV_REG_COUNT];
    logic [31:0] lcg_state = 32'd15921;
    int unsigned edge_count = 0;
    word_t       next_pc = 32'h0000_1000;
    tag_t        next_tag = '0;
    inst_t       chain_insts [CHAIN_LEN];

    core_out_t   exp_q [$];
    int unsigned due_q [$];
    string       name_q [$];
    core_out_t   cmp_exp;
    int unsigned cmp_due;
    string       cmp_name;

    rv_int_core u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .core_in   (core_in),
        .out_valid (out_valid),
        .core_out  (core_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    // ========================================================================
    // random numbers and instruction encoders.
    // ========================================================================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_range(input int unsigned n);
        return (lcg_next() >> 8) % n;
    endfunction

    function automatic reg_addr_t small_reg();
        return reg_addr_t'(rand_range(4) + 1);
    endfunction

    // k selects one of the 21 kept operations.
    function automatic inst_t alu_inst(input int unsigned k, input reg_addr_t rd,
                                       input reg_addr_t rs1, input reg_addr_t rs2);
        logic [31:0] r;
        inst_t       instr;
        r = lcg_next();
        case (k)
            0:  instr = {7'h00, rs2, rs1, 3'd0, rd, OPC_OP};
            1:  instr = {7'h20, rs2, rs1, 3'd0, rd, OPC_OP};
            2:  instr = {7'h00, rs2, rs1, 3'd7, rd, OPC_OP};
            3:  instr = {7'h00, rs2, rs1, 3'd6, rd, OPC_OP};
            4:  instr = {7'h00, rs2, rs1, 3'd4, rd, OPC_OP};
            5:  instr = {7'h00, rs2, rs1, 3'd1, rd, OPC_OP};
            6:  instr = {7'h00, rs2, rs1, 3'd5, rd, OPC_OP};
            7:  instr = {7'h20, rs2, rs1, 3'd5, rd, OPC_OP};
            8:  instr = {7'h00, rs2, rs1, 3'd2, rd, OPC_OP};
            9:  instr = {7'h00, rs2, rs1, 3'd3, rd, OPC_OP};
            10: instr = {r[11:0], rs1, 3'd0, rd, OPC_OP_IMM};
            11: instr = {r[11:0], rs1, 3'd7, rd, OPC_OP_IMM};
            12: instr = {r[11:0], rs1, 3'd6, rd, OPC_OP_IMM};
            13: instr = {r[11:0], rs1, 3'd4, rd, OPC_OP_IMM};
            14: instr = {7'h00, r[4:0], rs1, 3'd1, rd, OPC_OP_IMM};
            15: instr = {7'h00, r[4:0], rs1, 3'd5, rd, OPC_OP_IMM};
            16: instr = {7'h20, r[4:0], rs1, 3'd5, rd, OPC_OP_IMM};
            17: instr = {r[11:0], rs1, 3'd2, rd, OPC_OP_IMM};
            18: instr = {r[11:0], rs1, 3'd3, rd, OPC_OP_IMM};
            19: instr = {r[19:0], rd, OPC_LUI};
            default: instr = {r[19:0], rd, OPC_AUIPC};
        endcase
        return instr;
    endfunction

    // load, branch, rv32m and slli with the alternate funct7.
    function automatic inst_t odd_inst(input reg_addr_t rd);
        logic [31:0] r;
        inst_t       instr;
        r = lcg_next();
        case (r[1:0])
            2'd0:    instr = {r[31:12], rd, 7'b0000011};
            2'd1:    instr = {r[31:12], rd, 7'b1100011};
            2'd2:    instr = {7'h01, r[24:15], r[14:12], rd, OPC_OP};
            default: instr = {7'h20, r[24:20], r[19:15], 3'd1, rd, OPC_OP_IMM};
        endcase
        return instr;
    endfunction

    // ========================================================================
    // reference model.
    // ========================================================================
    function automatic core_out_t ref_exec(input inst_t instr, input word_t pc, input tag_t tag);
        core_out_t  res;
        word_t      a;
        word_t      b;
        word_t      val;
        logic [6:0] f7;
        logic       known;
        f7 = instr[31:25];
        a = model_regs[instr[19:15]];
        b = (instr[6:0] == OPC_OP) ? model_regs[instr[24:20]] : word_t'($signed(instr[31:20]));
        known = 1'b1;
        val = '0;
        case (instr[6:0])
            OPC_OP, OPC_OP_IMM: begin
                // immediate forms only look at funct7 for shifts.
                if (instr[6:0] == OPC_OP_IMM && instr[13:12] != 2'b01) begin
                    f7 = 7'h00;
                end
                case (instr[14:12])
                    3'd0: val = (f7 == 7'h20) ? a - b : a + b;
                    3'd1: val = a << b[4:0];
                    3'd2: val = word_t'($signed(a) < $signed(b));
                    3'd3: val = word_t'(a < b);
                    3'd4: val = a ^ b;
                    3'd5: val = (f7 == 7'h20) ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'd6: val = a | b;
                    default: val = a & b;
                endcase
                known = (f7 == 7'h00)
                    || (f7 == 7'h20 && (instr[14:12] == 3'd5 || instr[14:12] == 3'd0));
            end
            OPC_LUI:   val = {instr[31:12], 12'h000};
            OPC_AUIPC: val = pc + {instr[31:12], 12'h000};
            default:   known = 1'b0;
        endcase
        res.rd = instr[11:7];
        res.rf_wen = known && (instr[11:7] != 5'd0);
        res.value = val;
        res.tag = tag;
        if (res.rf_wen) begin
            model_regs[res.rd] = val;
        end
        return res;
    endfunction

    // ========================================================================
    // stimulus tasks.
    // ========================================================================
    task automatic issue_inst(input inst_t instr, input string name);
        @(posedge clk);
        in_valid <= 1'b1;
        core_in <= '{inst: instr, pc: next_pc, tag: next_tag};
        exp_q.push_back(ref_exec(instr, next_pc, next_tag));
        // the dut samples it at the next edge and raises out_valid two edges later.
        due_q.push_back(edge_count + 4);
        name_q.push_back(name);
        next_pc = next_pc + 32'd4;
        next_tag = next_tag + 16'd1;
    endtask

    task automatic idle_cycles(input int unsigned n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic load_reg(input reg_addr_t rd, input word_t value, input string name);
        word_t hi;
        hi = value + 32'h800;
        issue_inst({hi[31:12], rd, OPC_LUI}, name);
        issue_inst({value[11:0], rd, 3'd0, rd, OPC_OP_IMM}, name);
    endtask

    task automatic read_all(input string name);
        for (int r = 1; r < `RV_REG_COUNT; r++) begin
            issue_inst({12'h000, reg_addr_t'(r), 3'd0, reg_addr_t'(r), OPC_OP_IMM}, name);
        end
    endtask

    // ========================================================================
    // checking.
    // ========================================================================
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid was high with no instruction outstanding");
                $display("Test failed");
                $fatal(1, "unexpected completion");
            end else begin
                cmp_exp = exp_q.pop_front();
                cmp_due = due_q.pop_front();
                cmp_name = name_q.pop_front();
                check_value($sformatf("%s latency", cmp_name), 64'(cmp_due), 64'(edge_count));
                check_value($sformatf("%s tag", cmp_name), 64'(cmp_exp.tag), 64'(core_out.tag));
                check_value($sformatf("%s rd", cmp_name), 64'(cmp_exp.rd), 64'(core_out.rd));
                check_value($sformatf("%s rf_wen", cmp_name), 64'(cmp_exp.rf_wen),
                            64'(core_out.rf_wen));
                if (cmp_exp.rf_wen) begin
                    check_value($sformatf("%s value", cmp_name), 64'(cmp_exp.value),
                                64'(core_out.value));
                end
            end
        end else if (!reset && due_q.size() != 0 && due_q[0] <= edge_count) begin
            $display("an instruction did not complete two cycles after it was accepted");
            $display("Test failed");
            $fatal(1, "missing completion");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("the run took longer than the watchdog allows");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    // ========================================================================
    // test sequence.
    // ========================================================================
    initial begin
        reset <= 1'b1;
        in_valid <= 1'b0;
        core_in <= '0;
        for (int r = 0; r < `RV_REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        idle_cycles(8);
        read_all("reset zero");
        for (int round = 0; round < ALU_ROUNDS; round++) begin
            for (int k = 0; k < 21; k++) begin
                load_reg(5'd1, lcg_next(), "alu setup");
                load_reg(5'd2, lcg_next(), "alu setup");
                issue_inst(alu_inst(k, 5'd3, 5'd1, 5'd2), "alu ops");
            end
        end
        for (int i = 0; i < CHAIN_LEN; i++) begin
            chain_insts[i] = alu_inst(rand_range(21), small_reg(), small_reg(), small_reg());
            issue_inst(chain_insts[i], "dep chain");
        end
        // the same chain again, with gaps between strobes.
        for (int i = 0; i < CHAIN_LEN; i++) begin
            idle_cycles(rand_range(MAX_GAP + 1));
            issue_inst(chain_insts[i], "dep gaps");
        end
        for (int i = 0; i < N_ODD; i++) begin
            issue_inst(alu_inst(rand_range(21), 5'd0, small_reg(), small_reg()), "x0 write");
            issue_inst(odd_inst(reg_addr_t'(rand_range(31) + 1)), "unsupported");
        end
        read_all("readback");
        idle_cycles(1);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        idle_cycles(4);
        $display("Test passed");
        $finish;
    end

endmodule

//--- list.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_int_core.sv
tb/tb_rv_int_core.sv

//--- Makefile
# Verilator build and run for the integer execution slice.

VERILATOR ?= verilator
TOP       ?= tb_rv_int_core
DUT_TOP   ?= rv_int_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP DUT_TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
